// File: dcache_top.f
verilog/dcache_pkg.sv
verilog/dcache_store.sv
verilog/dcache_ctrl.sv
verilog/dcache_csr.sv
verilog/dcache_top.sv
verification/dcache_checker.sv
verification/dcache_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the cache testbench with Verilator and run it

set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
	--top-module dcache_tb \
	-Mdir obj_dir \
	-f dcache_top.f
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

output=$(./obj_dir/Vdcache_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qF "*** TEST PASSED ***"; then
	exit 0
fi
exit 1

// File: verification/dcache_tb.sv
`default_nettype none

module dcache_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int          BEATS      = 4;
	localparam int          WAIT_LIMIT = 200;
	localparam logic [31:0] SEED       = 32'h9737961d;
	localparam logic [31:0] MEM_KEY    = 32'h5a5a0000;

	logic        clock;
	logic        reset;
	logic        req_valid;
	logic [31:0] req_addr;
	logic        req_ready;
	logic        rsp_valid;
	logic [31:0] rsp_data;
	logic        mem_r_valid;
	logic [31:0] mem_r_addr;
	logic        mem_r_ready = 1'b0;
	logic [31:0] mem_r_data = '0;
	logic        mem_r_last = 1'b0;
	logic        s_awvalid;
	logic        s_awready;
	logic [31:0] s_awaddr;
	logic        s_wvalid;
	logic        s_wready;
	logic [31:0] s_wdata;
	logic        s_bvalid;
	logic        s_bready;
	logic [1:0]  s_bresp;
	logic        s_arvalid;
	logic        s_arready;
	logic [31:0] s_araddr;
	logic        s_rvalid;
	logic        s_rready;
	logic [31:0] s_rdata;
	logic [1:0]  s_rresp;
	logic        stall_en;
	logic [31:0] stall_rng = SEED;
	int          beat_cnt = 0;

	dcache_top #(.INDEX_W(4), .BEATS(BEATS)) u_dcache_top (
		.clock(clock), .reset(reset),
		.req_valid_i(req_valid), .req_addr_i(req_addr), .req_ready_o(req_ready),
		.rsp_valid_o(rsp_valid), .rsp_data_o(rsp_data),
		.mem_r_valid_o(mem_r_valid), .mem_r_addr_o(mem_r_addr),
		.mem_r_ready_i(mem_r_ready), .mem_r_data_i(mem_r_data), .mem_r_last_i(mem_r_last),
		.s_awvalid_i(s_awvalid), .s_awready_o(s_awready), .s_awaddr_i(s_awaddr),
		.s_wvalid_i(s_wvalid), .s_wready_o(s_wready), .s_wdata_i(s_wdata),
		.s_bvalid_o(s_bvalid), .s_bready_i(s_bready), .s_bresp_o(s_bresp),
		.s_arvalid_i(s_arvalid), .s_arready_o(s_arready), .s_araddr_i(s_araddr),
		.s_rvalid_o(s_rvalid), .s_rready_i(s_rready), .s_rdata_o(s_rdata),
		.s_rresp_o(s_rresp)
	);

	dcache_checker u_checker (
		.clock(clock), .reset(reset),
		.req_valid_i(req_valid), .req_ready_i(req_ready), .req_addr_i(req_addr),
		.rsp_valid_i(rsp_valid), .rsp_data_i(rsp_data),
		.bvalid_i(s_bvalid), .bready_i(s_bready), .bresp_i(s_bresp),
		.rvalid_i(s_rvalid), .rready_i(s_rready), .rresp_i(s_rresp)
	);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// memory burst model, first beat one cycle after valid is seen
	always @(posedge clock) begin
		if (reset) begin
			beat_cnt = 0;
			mem_r_ready <= 1'b0;
			mem_r_last  <= 1'b0;
		end else begin
			stall_rng = xorshift32(stall_rng);
			if (mem_r_valid && mem_r_ready) begin
				beat_cnt = mem_r_last ? 0 : beat_cnt + 1;
			end
			if (mem_r_valid && !(mem_r_ready && mem_r_last)
					&& !(stall_en && stall_rng[1:0] == 2'b00)) begin
				mem_r_ready <= 1'b1;
				mem_r_data  <= (mem_r_addr + 32'(beat_cnt * 4)) ^ MEM_KEY;
				mem_r_last  <= (beat_cnt == BEATS - 1);
			end else begin
				mem_r_ready <= 1'b0;  // stalled or idle
				mem_r_last  <= 1'b0;
			end
		end
	end

	task automatic abort_run(input string why);
		$display("timeout: %s", why);
		$display("*** TEST FAILED ***");
		$finish;
	endtask

	task automatic read_word(input logic [31:0] addr);
		int n;
		logic ok;
		req_valid <= 1'b1;
		req_addr  <= addr;
		ok = 1'b0;
		for (n = 0; n < WAIT_LIMIT && !ok; n++) begin
			@(posedge clock);
			ok = req_ready;
		end
		req_valid <= 1'b0;
		if (!ok) abort_run("read request was never accepted");
		ok = 1'b0;
		for (n = 0; n < WAIT_LIMIT && !ok; n++) begin
			@(posedge clock);
			ok = rsp_valid;
		end
		if (!ok) abort_run("no response to a read request");
	endtask

	task automatic write_reg(input logic [7:0] off, input logic [31:0] data);
		int n;
		logic ok;
		s_awvalid <= 1'b1;
		s_awaddr  <= {24'd0, off};
		s_wvalid  <= 1'b1;
		s_wdata   <= data;
		ok = 1'b0;
		for (n = 0; n < WAIT_LIMIT && !ok; n++) begin
			@(posedge clock);
			ok = s_awready && s_wready;  // both channels taken together
		end
		s_awvalid <= 1'b0;
		s_wvalid  <= 1'b0;
		if (!ok) abort_run("register write was never accepted");
		ok = 1'b0;
		for (n = 0; n < WAIT_LIMIT && !ok; n++) begin
			@(posedge clock);
			ok = s_bvalid;  // bready is tied high
		end
		if (!ok) abort_run("no write response");
	endtask

	task automatic read_reg(input logic [7:0] off, output logic [31:0] data);
		int n;
		logic ok;
		s_arvalid <= 1'b1;
		s_araddr  <= {24'd0, off};
		ok = 1'b0;
		for (n = 0; n < WAIT_LIMIT && !ok; n++) begin
			@(posedge clock);
			ok = s_arready;
		end
		s_arvalid <= 1'b0;
		if (!ok) abort_run("register read was never accepted");
		ok = 1'b0;
		for (n = 0; n < WAIT_LIMIT && !ok; n++) begin
			@(posedge clock);
			ok = s_rvalid;
		end
		if (!ok) abort_run("no read data");
		data = s_rdata;
	endtask

	task automatic check_counters(input logic [31:0] hits, input logic [31:0] misses);
		logic [31:0] rd;
		read_reg(dcache_pkg::CSR_HITS, rd);
		u_checker.check_reg("s_rdata_o hits", rd, hits);
		read_reg(dcache_pkg::CSR_MISSES, rd);
		u_checker.check_reg("s_rdata_o misses", rd, misses);
	endtask

	initial begin
		logic [31:0] rd;
		logic [31:0] addr_rng;
		logic [31:0] exp_hits;
		logic [31:0] exp_misses;
		logic        flushing;
		int          n;
		int          failed;
		reset     <= 1'b1;
		req_valid <= 1'b0;
		req_addr  <= '0;
		s_awvalid <= 1'b0;
		s_awaddr  <= '0;
		s_wvalid  <= 1'b0;
		s_wdata   <= '0;
		s_bready  <= 1'b1;
		s_arvalid <= 1'b0;
		s_araddr  <= '0;
		s_rready  <= 1'b1;
		stall_en  <= 1'b0;
		addr_rng   = SEED;
		exp_hits   = 32'd0;
		exp_misses = 32'd0;
		repeat (4) @(posedge clock);
		reset <= 1'b0;
		@(posedge clock);

		// cache comes up disabled
		for (n = 0; n < 8; n++) begin
			addr_rng = xorshift32(addr_rng);
			read_word(addr_rng & 32'hffff_fffc);
		end
		check_counters(exp_hits, exp_misses);
		u_checker.end_test("1 disabled reads");

		write_reg(dcache_pkg::CSR_CTRL, 32'h1);
		read_word(32'h0001_0040);
		read_word(32'h0001_0044);
		read_word(32'h0001_004c);
		exp_misses = exp_misses + 32'd1;
		exp_hits   = exp_hits + 32'd2;
		check_counters(exp_hits, exp_misses);
		u_checker.end_test("2 miss then hits");

		// four tags in set 5
		for (n = 0; n < 4; n++) begin
			read_word(32'h0002_0050 + (32'(n) << 16));
			read_word(32'h0002_0058 + (32'(n) << 16));
		end
		exp_misses = exp_misses + 32'd4;
		exp_hits   = exp_hits + 32'd4;
		check_counters(exp_hits, exp_misses);
		u_checker.end_test("3 one set");

		read_word(32'h0001_0048);
		exp_hits = exp_hits + 32'd1;
		write_reg(dcache_pkg::CSR_CTRL, 32'h3);
		flushing = 1'b1;
		for (n = 0; n < WAIT_LIMIT && flushing; n++) begin
			read_reg(dcache_pkg::CSR_CTRL, rd);
			flushing = rd[1];
		end
		if (flushing) abort_run("flush bit never cleared");
		u_checker.check_reg("s_rdata_o ctrl", rd, 32'h1);
		read_word(32'h0001_0044);
		exp_misses = exp_misses + 32'd1;
		check_counters(exp_hits, exp_misses);
		u_checker.end_test("4 flush");

		stall_en <= 1'b1;
		for (n = 0; n < 40; n++) begin
			addr_rng = xorshift32(addr_rng);
			read_word(addr_rng & 32'h0000_0ffc);  // small range so lines repeat
		end
		write_reg(dcache_pkg::CSR_HITS, 32'hffff_ffff);
		write_reg(dcache_pkg::CSR_MISSES, 32'hffff_ffff);
		check_counters(32'd0, 32'd0);
		u_checker.end_test("5 random with stalls");

		u_checker.summary(failed);
		if (failed == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: verification/dcache_checker.sv
`default_nettype none

module dcache_checker (
	input wire        clock,
	input wire        reset,
	input wire        req_valid_i,
	input wire        req_ready_i,
	input wire [31:0] req_addr_i,
	input wire        rsp_valid_i,
	input wire [31:0] rsp_data_i,
	input wire        bvalid_i,
	input wire        bready_i,
	input wire [1:0]  bresp_i,
	input wire        rvalid_i,
	input wire        rready_i,
	input wire [1:0]  rresp_i
);

	timeunit 1ns;
	timeprecision 1ps;

	localparam logic [31:0] MEM_KEY = 32'h5a5a0000;

	logic [31:0] pending_q [$];  // accepted requests, oldest first
	logic [31:0] rsp_addr;
	int rsp_checks = 0;
	int rsp_errors = 0;
	int reg_checks = 0;
	int reg_errors = 0;
	int base_checks = 0;  // totals when the current test started
	int base_errors = 0;

	// every memory word holds its own address xor the key
	function automatic logic [31:0] expected_word(input logic [31:0] addr);
		return {addr[31:2], 2'b00} ^ MEM_KEY;
	endfunction

	task automatic compare_bus(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		rsp_checks++;
		if (got !== exp) begin
			rsp_errors++;
			$display("[FAIL] %s: got %h expected %h", name, got, exp);
		end
	endtask

	always @(posedge clock) begin
		if (!reset) begin
			if (rsp_valid_i) begin
				if (pending_q.size() == 0) begin
					rsp_errors++;
					$display("error: a response came with no request outstanding");
				end else begin
					rsp_addr = pending_q.pop_front();
					compare_bus($sformatf("rsp_data_o at %h", rsp_addr), rsp_data_i,
						expected_word(rsp_addr));
				end
			end
			if (req_valid_i && req_ready_i) begin
				pending_q.push_back(req_addr_i);
			end
			if (bvalid_i && bready_i) begin
				compare_bus("s_bresp_o", 32'(bresp_i), 32'd0);  // OKAY only
			end
			if (rvalid_i && rready_i) begin
				compare_bus("s_rresp_o", 32'(rresp_i), 32'd0);
			end
		end
	end

	// register readback, called from the testbench top
	task automatic check_reg(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		reg_checks++;
		if (got !== exp) begin
			reg_errors++;
			$display("[FAIL] %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic end_test(input string name);
		int checks;
		int errors;
		if (pending_q.size() != 0) begin
			reg_errors++;
			$display("error: test %s ended with requests still unanswered", name);
		end
		checks = rsp_checks + reg_checks;
		errors = rsp_errors + reg_errors;
		$display("test %s: %0d checks, %0d failed", name, checks - base_checks,
			errors - base_errors);
		base_checks = checks;
		base_errors = errors;
	endtask

	task automatic summary(output int failed);
		failed = rsp_errors + reg_errors;
		$display("total: %0d checks, %0d failed", rsp_checks + reg_checks, failed);
	endtask

endmodule

`default_nettype wire

// File: verilog/dcache_top.sv
`default_nettype none

module dcache_top #(
	parameter int INDEX_W = dcache_pkg::INDEX_W_DEF,
	parameter int BEATS   = 4
) (
	input  wire         clock,
	input  wire         reset,
	input  wire         req_valid_i,
	input  wire [31:0]  req_addr_i,
	output logic        req_ready_o,
	output logic        rsp_valid_o,
	output logic [31:0] rsp_data_o,
	output logic        mem_r_valid_o,
	output logic [31:0] mem_r_addr_o,
	input  wire         mem_r_ready_i,
	input  wire [31:0]  mem_r_data_i,
	input  wire         mem_r_last_i,
	input  wire         s_awvalid_i,
	output logic        s_awready_o,
	input  wire [31:0]  s_awaddr_i,
	input  wire         s_wvalid_i,
	output logic        s_wready_o,
	input  wire [31:0]  s_wdata_i,
	output logic        s_bvalid_o,
	input  wire         s_bready_i,
	output logic [1:0]  s_bresp_o,
	input  wire         s_arvalid_i,
	output logic        s_arready_o,
	input  wire [31:0]  s_araddr_i,
	output logic        s_rvalid_o,
	input  wire         s_rready_i,
	output logic [31:0] s_rdata_o,
	output logic [1:0]  s_rresp_o
);

	dcache_pkg::addr_u   lookup_addr;
	logic                fill_beat;
	logic                fill_en;
	logic                flush_all;
	logic                hit;
	logic [BEATS*32-1:0] line;
	logic                cache_en;
	logic                flush_req;
	logic                flush_done;
	logic                hit_pulse;
	logic                miss_pulse;

	dcache_store #(.INDEX_W(INDEX_W), .BEATS(BEATS)) u_store (
		.clock        (clock),
		.reset        (reset),
		.lookup_addr_i(lookup_addr),
		.fill_en_i    (fill_en),
		.fill_data_i  (mem_r_data_i),  // beats shift straight in from memory
		.fill_beat_i  (fill_beat),
		.flush_all_i  (flush_all),
		.hit_o        (hit),
		.line_o       (line)
	);

	dcache_ctrl #(.INDEX_W(INDEX_W), .BEATS(BEATS)) u_ctrl (
		.clock        (clock),
		.reset        (reset),
		.req_valid_i  (req_valid_i),
		.req_addr_i   (req_addr_i),
		.req_ready_o  (req_ready_o),
		.rsp_valid_o  (rsp_valid_o),
		.rsp_data_o   (rsp_data_o),
		.mem_r_valid_o(mem_r_valid_o),
		.mem_r_addr_o (mem_r_addr_o),
		.mem_r_ready_i(mem_r_ready_i),
		.mem_r_data_i (mem_r_data_i),
		.mem_r_last_i (mem_r_last_i),
		.lookup_addr_o(lookup_addr),
		.fill_beat_o  (fill_beat),
		.fill_en_o    (fill_en),
		.flush_all_o  (flush_all),
		.hit_i        (hit),
		.line_i       (line),
		.cache_en_i   (cache_en),
		.flush_req_i  (flush_req),
		.flush_done_o (flush_done),
		.hit_pulse_o  (hit_pulse),
		.miss_pulse_o (miss_pulse)
	);

	dcache_csr u_csr (
		.clock       (clock),
		.reset       (reset),
		.s_awvalid_i (s_awvalid_i),
		.s_awready_o (s_awready_o),
		.s_awaddr_i  (s_awaddr_i),
		.s_wvalid_i  (s_wvalid_i),
		.s_wready_o  (s_wready_o),
		.s_wdata_i   (s_wdata_i),
		.s_bvalid_o  (s_bvalid_o),
		.s_bready_i  (s_bready_i),
		.s_arvalid_i (s_arvalid_i),
		.s_arready_o (s_arready_o),
		.s_araddr_i  (s_araddr_i),
		.s_rvalid_o  (s_rvalid_o),
		.s_rready_i  (s_rready_i),
		.s_rdata_o   (s_rdata_o),
		.s_bresp_o   (s_bresp_o),
		.s_rresp_o   (s_rresp_o),
		.cache_en_o  (cache_en),
		.flush_req_o (flush_req),
		.flush_done_i(flush_done),
		.hit_pulse_i (hit_pulse),
		.miss_pulse_i(miss_pulse)
	);

endmodule

`default_nettype wire

// File: verilog/dcache_csr.sv
`default_nettype none

module dcache_csr (
	input  wire         clock,
	input  wire         reset,
	input  wire         s_awvalid_i,
	output logic        s_awready_o,
	input  wire [31:0]  s_awaddr_i,
	input  wire         s_wvalid_i,
	output logic        s_wready_o,
	input  wire [31:0]  s_wdata_i,
	output logic        s_bvalid_o,
	input  wire         s_bready_i,
	input  wire         s_arvalid_i,
	output logic        s_arready_o,
	input  wire [31:0]  s_araddr_i,
	output logic        s_rvalid_o,
	input  wire         s_rready_i,
	output logic [31:0] s_rdata_o,
	output logic [1:0]  s_bresp_o,
	output logic [1:0]  s_rresp_o,
	output logic        cache_en_o,
	output logic        flush_req_o,
	input  wire         flush_done_i,
	input  wire         hit_pulse_i,
	input  wire         miss_pulse_i
);

	logic        wr_fire;
	logic        rd_fire;
	logic [7:0]  wr_off;
	logic [31:0] hits_q;
	logic [31:0] misses_q;

	// address and data are taken in the same cycle
	assign s_awready_o = s_awvalid_i && s_wvalid_i && !s_bvalid_o;
	assign s_wready_o  = s_awready_o;
	assign wr_fire     = s_awready_o;
	assign wr_off      = s_awaddr_i[7:0];

	assign s_arready_o = !s_rvalid_o;
	assign rd_fire     = s_arvalid_i && s_arready_o;

	assign s_bresp_o = 2'b00;  // OKAY
	assign s_rresp_o = 2'b00;

	always_ff @(posedge clock) begin
		if (reset) begin
			s_bvalid_o <= 1'b0;
			s_rvalid_o <= 1'b0;
		end else begin
			if (wr_fire) begin
				s_bvalid_o <= 1'b1;
			end else if (s_bready_i) begin
				s_bvalid_o <= 1'b0;
			end
			if (rd_fire) begin
				s_rvalid_o <= 1'b1;
			end else if (s_rready_i) begin
				s_rvalid_o <= 1'b0;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			cache_en_o  <= 1'b0;
			flush_req_o <= 1'b0;
		end else if (wr_fire && wr_off == dcache_pkg::CSR_CTRL) begin
			cache_en_o <= s_wdata_i[0];
			if (s_wdata_i[1]) begin
				flush_req_o <= 1'b1;
			end else if (flush_done_i) begin
				flush_req_o <= 1'b0;
			end
		end else if (flush_done_i) begin
			flush_req_o <= 1'b0;  // self-clearing
		end
	end

	// saturating counters, a write clears
	always_ff @(posedge clock) begin
		if (reset) begin
			hits_q <= '0;
		end else if (wr_fire && wr_off == dcache_pkg::CSR_HITS) begin
			hits_q <= '0;
		end else if (hit_pulse_i && hits_q != '1) begin
			hits_q <= hits_q + 32'd1;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			misses_q <= '0;
		end else if (wr_fire && wr_off == dcache_pkg::CSR_MISSES) begin
			misses_q <= '0;
		end else if (miss_pulse_i && misses_q != '1) begin
			misses_q <= misses_q + 32'd1;
		end
	end

	always_ff @(posedge clock) begin
		if (rd_fire) begin
			case (s_araddr_i[7:0])
				dcache_pkg::CSR_CTRL:   s_rdata_o <= {30'd0, flush_req_o, cache_en_o};
				dcache_pkg::CSR_HITS:   s_rdata_o <= hits_q;
				dcache_pkg::CSR_MISSES: s_rdata_o <= misses_q;
				default:                s_rdata_o <= '0;
			endcase
		end
	end

	assert property (@(posedge clock) disable iff (reset)
		(s_bvalid_o && !s_bready_i) |=> s_bvalid_o)
		else $error("write response dropped before bready");

endmodule

`default_nettype wire

// File: verilog/dcache_ctrl.sv
`default_nettype none

module dcache_ctrl #(
	parameter int INDEX_W = 4,
	parameter int BEATS   = 4
) (
	input  wire                   clock,
	input  wire                   reset,
	input  wire                   req_valid_i,
	input  wire [31:0]            req_addr_i,
	output logic                  req_ready_o,
	output logic                  rsp_valid_o,
	output logic [31:0]           rsp_data_o,
	output logic                  mem_r_valid_o,
	output logic [31:0]           mem_r_addr_o,
	input  wire                   mem_r_ready_i,
	input  wire [31:0]            mem_r_data_i,
	input  wire                   mem_r_last_i,
	output dcache_pkg::addr_u     lookup_addr_o,
	output logic                  fill_beat_o,
	output logic                  fill_en_o,
	output logic                  flush_all_o,
	input  wire                   hit_i,
	input  wire [BEATS*32-1:0]    line_i,
	input  wire                   cache_en_i,
	input  wire                   flush_req_i,
	output logic                  flush_done_o,
	output logic                  hit_pulse_o,
	output logic                  miss_pulse_o
);

	localparam logic [1:0] ST_IDLE   = 2'd0;
	localparam logic [1:0] ST_HIT    = 2'd1;
	localparam logic [1:0] ST_REFILL = 2'd2;
	localparam logic [1:0] ST_FLUSH  = 2'd3;
	localparam int WORD_W = $clog2(BEATS);

	if (dcache_pkg::OFFSET_W + INDEX_W > 31 || BEATS * 4 != (1 << dcache_pkg::OFFSET_W)) begin
		: g_bad_layout
		$error("line geometry does not fit the address layout");
	end

	logic [1:0]        state_q;
	logic              run_q;      // low until the first cycle out of reset
	logic              alloc_q;    // this refill allocates a way
	logic              fill_en_q;
	logic [WORD_W-1:0] beat_q;
	logic [31:0]       bypass_q;   // requested word caught off the burst
	dcache_pkg::addr_u addr_q;
	logic [WORD_W-1:0] word;
	logic              accept;
	logic              beat_fire;
	logic              last_fire;

	assign word      = addr_q.f.offset[2 +: WORD_W];
	assign beat_fire = (state_q == ST_REFILL) && mem_r_ready_i;
	assign last_fire = beat_fire && mem_r_last_i;

	// no accept while the line of the last refill is being written
	assign req_ready_o = run_q && (state_q == ST_IDLE) && !fill_en_q && !flush_req_i;
	assign accept      = req_valid_i && req_ready_o;

	assign lookup_addr_o = req_ready_o ? req_addr_i : addr_q.raw;
	assign hit_pulse_o   = accept && cache_en_i && hit_i;
	assign miss_pulse_o  = accept && cache_en_i && !hit_i;

	assign mem_r_valid_o = (state_q == ST_REFILL);
	assign mem_r_addr_o  = {addr_q.raw[31:dcache_pkg::OFFSET_W], {dcache_pkg::OFFSET_W{1'b0}}};
	assign fill_beat_o   = beat_fire && alloc_q;
	assign fill_en_o     = fill_en_q;
	assign flush_all_o   = (state_q == ST_FLUSH);
	assign flush_done_o  = (state_q == ST_FLUSH);

	assign rsp_valid_o = (state_q == ST_HIT) || last_fire;

	always_comb begin
		if (state_q == ST_HIT) begin
			rsp_data_o = line_i[word*32 +: 32];
		end else if (beat_q == word) begin
			rsp_data_o = mem_r_data_i;  // wanted word is on the bus now
		end else begin
			rsp_data_o = bypass_q;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state_q   <= ST_IDLE;
			run_q     <= 1'b0;
			alloc_q   <= 1'b0;
			fill_en_q <= 1'b0;
			beat_q    <= '0;
		end else begin
			run_q     <= 1'b1;
			fill_en_q <= last_fire && alloc_q;  // write the line the cycle after
			case (state_q)
				ST_IDLE: begin
					if (accept) begin
						alloc_q <= cache_en_i;
						beat_q  <= '0;
						state_q <= (cache_en_i && hit_i) ? ST_HIT : ST_REFILL;
					end else if (flush_req_i && run_q && !fill_en_q) begin
						state_q <= ST_FLUSH;
					end
				end
				ST_HIT: begin
					state_q <= ST_IDLE;
				end
				ST_REFILL: begin
					if (beat_fire) begin
						beat_q <= beat_q + WORD_W'(1);
					end
					if (last_fire) begin
						state_q <= ST_IDLE;
					end
				end
				default: begin
					state_q <= ST_IDLE;  // flush takes one cycle
				end
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			addr_q <= req_addr_i;
		end
		if (beat_fire && beat_q == word) begin
			bypass_q <= mem_r_data_i;
		end
	end

	assert property (@(posedge clock) disable iff (reset)
		(state_q == ST_REFILL && rsp_valid_o) |=> !rsp_valid_o)
		else $error("two responses in a row on a refill");

endmodule

`default_nettype wire

// File: verilog/dcache_store.sv
`default_nettype none

module dcache_store #(
	parameter int INDEX_W = 4,
	parameter int BEATS   = 4
) (
	input  wire                       clock,
	input  wire                       reset,
	input  wire dcache_pkg::addr_u    lookup_addr_i,
	input  wire                       fill_en_i,
	input  wire [31:0]                fill_data_i,
	input  wire                       fill_beat_i,
	input  wire                       flush_all_i,
	output logic                      hit_o,
	output logic [BEATS*32-1:0]       line_o
);

	localparam int SETS   = 1 << INDEX_W;
	localparam int TAG_W  = 32 - dcache_pkg::OFFSET_W - INDEX_W;
	localparam int LINE_W = BEATS * 32;
	localparam int WAY_W  = $clog2(dcache_pkg::WAYS);

	logic [LINE_W-1:0] data_mem [dcache_pkg::WAYS][SETS];
	logic [TAG_W-1:0]  tag_mem  [dcache_pkg::WAYS][SETS];
	logic [SETS-1:0][dcache_pkg::WAYS-1:0] valid_q;

	logic [LINE_W-1:0]           fill_buf_q;  // refill beats, oldest at the bottom
	logic [WAY_W-1:0]            victim_q;
	logic [dcache_pkg::WAYS-1:0] way_hit;
	logic [INDEX_W-1:0]          idx;
	logic [TAG_W-1:0]            tag;

	// slice the raw view, the index width is a parameter here
	assign idx = lookup_addr_i.raw[dcache_pkg::OFFSET_W +: INDEX_W];
	assign tag = lookup_addr_i.raw[31 -: TAG_W];

	// parallel tag compare over all ways
	always_comb begin
		line_o = '0;
		for (int w = 0; w < dcache_pkg::WAYS; w++) begin
			way_hit[w] = valid_q[idx][w] && (tag_mem[w][idx] == tag);
			if (way_hit[w]) begin
				line_o = line_o | data_mem[w][idx];
			end
		end
	end

	assign hit_o = |way_hit;

	// free-running victim pick
	always_ff @(posedge clock) begin
		if (reset) begin
			victim_q <= '0;
		end else begin
			victim_q <= victim_q + WAY_W'(1);
		end
	end

	always_ff @(posedge clock) begin
		if (fill_beat_i) begin
			fill_buf_q <= {fill_data_i, fill_buf_q[LINE_W-1:32]};
		end
	end

	always_ff @(posedge clock) begin
		if (fill_en_i) begin
			data_mem[victim_q][idx] <= fill_buf_q;
			tag_mem[victim_q][idx]  <= tag;
		end
	end

	always_ff @(posedge clock) begin
		if (reset || flush_all_i) begin
			valid_q <= '0;
		end else if (fill_en_i) begin
			valid_q[idx][victim_q] <= 1'b1;
		end
	end

	// a line is only ever allocated on a miss, so tags never alias
	assert property (@(posedge clock) disable iff (reset) $onehot0(way_hit))
		else $error("more than one way hit in set %0d", idx);

endmodule

`default_nettype wire

// File: verilog/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

	localparam int OFFSET_W    = 4;  // 16-byte line
	localparam int WAYS        = 4;
	localparam int INDEX_W_DEF = 4;  // default set-index width
	localparam int TAG_W       = 32 - OFFSET_W - INDEX_W_DEF;

	// tag/index/offset split of a request address
	typedef struct packed {
		logic [TAG_W-1:0]       tag;
		logic [INDEX_W_DEF-1:0] index;
		logic [OFFSET_W-1:0]    offset;
	} addr_fields_t;

	typedef union packed {
		logic [31:0]  raw;
		addr_fields_t f;
	} addr_u;

	// register byte offsets on the AXI4-Lite port
	localparam logic [7:0] CSR_CTRL   = 8'h00;
	localparam logic [7:0] CSR_HITS   = 8'h04;
	localparam logic [7:0] CSR_MISSES = 8'h08;

endpackage

`default_nettype wire
